// File: logic/pu_ahb3_pkg.sv
////////////////////////////////////////////////////////////
// AHB-Lite processing unit package
// Widths, memory map, PMA encodings and bus structs
////////////////////////////////////////////////////////////

`default_nettype none

package pu_ahb3_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////

  // Data and physical address width
  localparam int xlen = 32;
  localparam int plen = 32;

  // Number of PMA regions
  localparam int pma_cnt = 4;

  // SRAM geometry in words
  localparam int mem_depth = 256;
  localparam int mem_aw    = 8;

  ////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////

  // Bottom of region 0
  localparam logic [plen-1:0] pma_base     = 32'h8000_0000;
  // End of code memory
  localparam logic [plen-1:0] code_top     = 32'h8000_0400;
  // Host mailbox and UART transmit register
  localparam logic [plen-1:0] tohost_addr  = 32'h8000_1000;
  localparam logic [plen-1:0] uart_tx_addr = 32'h8000_1080;
  // End of data memory
  localparam logic [plen-1:0] data_top     = 32'h8000_2000;

  // AHB-Lite transfer types
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  // AHB-Lite response codes
  localparam logic hresp_okay  = 1'b0;
  localparam logic hresp_error = 1'b1;

  ////////////////////////////////////////////////////////////
  // PMA types
  ////////////////////////////////////////////////////////////

  // Region match mode, encoding 3 never matches
  typedef enum logic [1:0] {tor = 2'd0, na4 = 2'd1, napot = 2'd2} pma_match_e;

  typedef enum logic {main = 1'b0, io = 1'b1} mem_type_e;

  // One table entry
  typedef struct packed {
    pma_match_e      match_mode;
    mem_type_e       mem_type;
    logic            readable;
    logic            writable;
    logic            target;     // 0 instruction bus, 1 data bus
    logic [plen-1:0] addr;       // Byte address, or NAPOT word for napot
  } pma_cfg_t;

  // Checker result
  typedef struct packed {
    logic      hit;
    mem_type_e mem_type;
    logic      readable;
    logic      writable;
    logic      target;
  } pma_attr_t;

  ////////////////////////////////////////////////////////////
  // AHB-Lite bus
  ////////////////////////////////////////////////////////////

  // Master to slave, single word transfers only
  typedef struct packed {
    logic            hsel;
    logic [plen-1:0] haddr;
    logic            hwrite;
    logic [1:0]      htrans;
    logic [xlen-1:0] hwdata;
  } ahb_req_t;

  // Slave to master
  typedef struct packed {
    logic [xlen-1:0] hrdata;
    logic            hready;
    logic            hresp;
  } ahb_rsp_t;

endpackage

`default_nettype wire

// File: logic/pu_pma_checker.sv
////////////////////////////////////////////////////////////
// PMA checker
// Priority match of an address against the region table
////////////////////////////////////////////////////////////

`default_nettype none

module pu_pma_checker
  import pu_ahb3_pkg::*;
(
  input  wire pma_cfg_t [pma_cnt-1:0] pma_table,
  input  wire logic     [plen-1:0]    addr,
  output pma_attr_t                   attr
);

  // Per region match flags
  logic [pma_cnt-1:0] match;

  // Word address for NAPOT compare
  logic [plen-1:0] addr_wd;

  assign addr_wd = {2'b00, addr[plen-1:2]};

  ////////////////////////////////////////////////////////////
  // Region match
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < pma_cnt; i++) begin : g_region
    // Lower TOR bound
    logic [plen-1:0] tor_lo;
    // Word bits ignored by NAPOT
    logic [plen-1:0] napot_ign;
    logic            tor_hit;
    logic            na4_hit;
    logic            napot_hit;

    // First entry starts at the fixed base
    if (i == 0) begin : g_first
      assign tor_lo = pma_base;
    end else begin : g_next
      // Previous entry's top
      assign tor_lo = pma_table[i-1].addr;
    end

    // Range check, top is exclusive
    assign tor_hit = (addr >= tor_lo) && (addr < pma_table[i].addr);

    // Single word
    assign na4_hit = (addr[plen-1:2] == pma_table[i].addr[plen-1:2]);

    // Trailing ones plus the next zero give the ignored bits
    assign napot_ign = pma_table[i].addr ^ (pma_table[i].addr + 1'b1);
    assign napot_hit = (((addr_wd ^ pma_table[i].addr) & ~napot_ign) == '0);

    // Pick by mode
    assign match[i] = (pma_table[i].match_mode == tor)   ? tor_hit   :
                      (pma_table[i].match_mode == na4)   ? na4_hit   :
                      (pma_table[i].match_mode == napot) ? napot_hit :
                                                           1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////////////////////////

  // Walk down so the lowest index wins
  always_comb begin
    attr = '0;
    for (int i = pma_cnt - 1; i >= 0; i--) begin
      if (match[i]) begin
        attr.hit      = 1'b1;
        attr.mem_type = pma_table[i].mem_type;
        attr.readable = pma_table[i].readable;
        attr.writable = pma_table[i].writable;
        attr.target   = pma_table[i].target;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/pu_dbg_bus_master.sv
////////////////////////////////////////////////////////////
// Debug port bus master
// Checked single word AHB-Lite transfers from host strobes
////////////////////////////////////////////////////////////

`default_nettype none

module pu_dbg_bus_master
  import pu_ahb3_pkg::*;
(
  input  wire logic            HCLK,
  input  wire logic            rst_n,

  // Host side
  input  wire logic            dbg_strb,
  input  wire logic            dbg_we,
  input  wire logic [plen-1:0] dbg_addr,
  input  wire logic [xlen-1:0] dbg_dati,
  output logic      [xlen-1:0] dbg_dato,
  output logic                 dbg_ack,
  output logic                 dbg_err,

  // PMA lookup
  output logic      [plen-1:0] pma_addr,
  input  wire pma_attr_t       pma_attr,

  // Instruction and data buses
  output ahb_req_t             ins_req,
  input  wire ahb_rsp_t        ins_rsp,
  output ahb_req_t             dat_req,
  input  wire ahb_rsp_t        dat_rsp
);

  // Idle, check and address, bus transfer
  typedef enum logic [1:0] {st_idle, st_addr, st_data} state_e;

  state_e          state;

  // Registered request
  logic [plen-1:0] req_addr;
  logic            req_we;
  logic [xlen-1:0] req_wdata;

  // Address phase outstanding
  logic            aphase;
  // Selected bus, 1 for data
  logic            tgt;

  logic            deny;
  ahb_rsp_t        bus_rsp;

  ////////////////////////////////////////////////////////////
  // Access check
  ////////////////////////////////////////////////////////////

  assign pma_addr = req_addr;

  // No region, or the access kind is not allowed
  assign deny = !pma_attr.hit
             || ( req_we && !pma_attr.writable)
             || (!req_we && !pma_attr.readable);

  // Response of the bus in use
  assign bus_rsp = tgt ? dat_rsp : ins_rsp;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      aphase   <= 1'b0;
      tgt      <= 1'b0;
      dbg_ack  <= 1'b0;
      dbg_err  <= 1'b0;
      dbg_dato <= '0;
    end else begin
      // Single cycle pulses
      dbg_ack <= 1'b0;
      dbg_err <= 1'b0;
      case (state)
        // Strobes while busy are dropped
        st_idle: begin
          if (dbg_strb) begin
            state <= st_addr;
          end
        end
        // Checker result settles this cycle
        st_addr: begin
          if (deny) begin
            dbg_ack <= 1'b1;
            dbg_err <= 1'b1;
            state   <= st_idle;
          end else begin
            aphase <= 1'b1;
            tgt    <= pma_attr.target;
            state  <= st_data;
          end
        end
        // Address phase then data phase, both end on hready
        st_data: begin
          if (bus_rsp.hready) begin
            if (aphase) begin
              aphase <= 1'b0;
            end else begin
              dbg_ack <= 1'b1;
              dbg_err <= (bus_rsp.hresp == hresp_error);
              if (!req_we) begin
                dbg_dato <= bus_rsp.hrdata;
              end
              state <= st_idle;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Request capture, word aligned
  always_ff @(posedge HCLK) begin
    if (state == st_idle && dbg_strb) begin
      req_addr  <= {dbg_addr[plen-1:2], 2'b00};
      req_we    <= dbg_we;
      req_wdata <= dbg_dati;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus drive
  ////////////////////////////////////////////////////////////

  // Write data stays valid through the data phase
  always_comb begin
    ins_req        = '0;
    dat_req        = '0;
    ins_req.htrans = htrans_idle;
    dat_req.htrans = htrans_idle;
    if (aphase && !tgt) begin
      ins_req.hsel   = 1'b1;
      ins_req.htrans = htrans_nonseq;
    end
    if (aphase && tgt) begin
      dat_req.hsel   = 1'b1;
      dat_req.htrans = htrans_nonseq;
    end
    ins_req.haddr  = req_addr;
    ins_req.hwrite = req_we;
    ins_req.hwdata = req_wdata;
    dat_req.haddr  = req_addr;
    dat_req.hwrite = req_we;
    dat_req.hwdata = req_wdata;
  end

endmodule

`default_nettype wire

// File: logic/pu_ahb3_spram.sv
////////////////////////////////////////////////////////////
// AHB-Lite single port SRAM, zero wait states
////////////////////////////////////////////////////////////

`default_nettype none

module pu_ahb3_spram
  import pu_ahb3_pkg::*;
(
  input  wire logic     HCLK,
  input  wire logic     rst_n,

  input  wire ahb_req_t req,
  output ahb_rsp_t      rsp
);

  // Storage, one word per entry
  logic [xlen-1:0]   mem [mem_depth];

  // Data phase state
  logic              dph_vld;
  logic              dph_we;
  logic [mem_aw-1:0] dph_idx;

  // Accepted address phase
  logic              aph_take;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  // Only nonseq transfers, no bursts here
  assign aph_take = req.hsel && (req.htrans == htrans_nonseq);

  always_ff @(posedge HCLK or negedge rst_n) begin
    if (!rst_n) begin
      dph_vld <= 1'b0;
      dph_we  <= 1'b0;
    end else begin
      dph_vld <= aph_take;
      dph_we  <= aph_take && req.hwrite;
    end
  end

  // Word index from bits 9 down to 2
  always_ff @(posedge HCLK) begin
    if (aph_take) begin
      dph_idx <= req.haddr[mem_aw+1:2];
    end
  end

  ////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////

  // Write lands at the end of the data phase
  always_ff @(posedge HCLK) begin
    if (dph_vld && dph_we) begin
      mem[dph_idx] <= req.hwdata;
    end
  end

  // Read word only during a read data phase
  assign rsp.hrdata = (dph_vld && !dph_we) ? mem[dph_idx] : '0;

  // Never stalls, never errors
  assign rsp.hready = 1'b1;
  assign rsp.hresp  = hresp_okay;

endmodule

`default_nettype wire

// File: logic/pu_riscv_synthesis.sv
////////////////////////////////////////////////////////////
// Processing unit top
// PMA table, debug bus master and two AHB-Lite SRAMs
////////////////////////////////////////////////////////////

`default_nettype none

module pu_riscv_synthesis
  import pu_ahb3_pkg::*;
(
  input  wire logic            HCLK,
  input  wire logic            rst_n,

  // Debug port
  input  wire logic            dbg_strb,
  input  wire logic            dbg_we,
  input  wire logic [plen-1:0] dbg_addr,
  input  wire logic [xlen-1:0] dbg_dati,
  output logic      [xlen-1:0] dbg_dato,
  output logic                 dbg_ack,
  output logic                 dbg_err
);

  ////////////////////////////////////////////////////////////
  // PMA table
  ////////////////////////////////////////////////////////////

  pma_cfg_t [pma_cnt-1:0] pma_table;

  // Code memory
  assign pma_table[0] = '{match_mode: tor, mem_type: main, readable: 1'b1,
                          writable: 1'b1, target: 1'b0, addr: code_top};

  // Host mailbox, 16 bytes, NAPOT word with one trailing one
  assign pma_table[1] = '{match_mode: napot, mem_type: io, readable: 1'b0,
                          writable: 1'b1, target: 1'b1,
                          addr: (tohost_addr >> 2) | plen'(1)};

  // UART transmit word
  assign pma_table[2] = '{match_mode: na4, mem_type: io, readable: 1'b0,
                          writable: 1'b1, target: 1'b1, addr: uart_tx_addr};

  // Data memory, starts at the UART word
  assign pma_table[3] = '{match_mode: tor, mem_type: main, readable: 1'b1,
                          writable: 1'b1, target: 1'b1, addr: data_top};

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////

  logic [plen-1:0] pma_addr;
  pma_attr_t       pma_attr;

  ahb_req_t        ins_req;
  ahb_rsp_t        ins_rsp;
  ahb_req_t        dat_req;
  ahb_rsp_t        dat_rsp;

  // Host strobes to bus transfers
  pu_dbg_bus_master u_bus_master (
    .HCLK     (HCLK),
    .rst_n    (rst_n),
    .dbg_strb (dbg_strb),
    .dbg_we   (dbg_we),
    .dbg_addr (dbg_addr),
    .dbg_dati (dbg_dati),
    .dbg_dato (dbg_dato),
    .dbg_ack  (dbg_ack),
    .dbg_err  (dbg_err),
    .pma_addr (pma_addr),
    .pma_attr (pma_attr),
    .ins_req  (ins_req),
    .ins_rsp  (ins_rsp),
    .dat_req  (dat_req),
    .dat_rsp  (dat_rsp)
  );

  pu_pma_checker u_pma_checker (
    .pma_table (pma_table),
    .addr      (pma_addr),
    .attr      (pma_attr)
  );

  // Instruction memory
  pu_ahb3_spram instruction_ahb3 (
    .HCLK  (HCLK),
    .rst_n (rst_n),
    .req   (ins_req),
    .rsp   (ins_rsp)
  );

  // Data memory
  pu_ahb3_spram data_ahb3 (
    .HCLK  (HCLK),
    .rst_n (rst_n),
    .req   (dat_req),
    .rsp   (dat_rsp)
  );

endmodule

`default_nettype wire

// File: bench/pu_riscv_synthesis_tb.sv
////////////////////////////////////////////////////////////
// Processing unit testbench
// Directed debug port accesses against code, data and IO
////////////////////////////////////////////////////////////

`default_nettype none

module pu_riscv_synthesis_tb
  import pu_ahb3_pkg::*;
();

  localparam int clk_period = 100;
  // Upper bound on debug accesses over all tests
  localparam int n_access   = 110;

  logic            HCLK;
  logic            rst_n;
  logic            dbg_strb;
  logic            dbg_we;
  logic [plen-1:0] dbg_addr;
  logic [xlen-1:0] dbg_dati;
  logic [xlen-1:0] dbg_dato;
  logic            dbg_ack;
  logic            dbg_err;

  integer seed = 24;

  int data_errs;
  int flag_errs;
  int lat_errs;
  int misc_errs;

  // Expected contents, indexed by address bits 9 down to 2
  logic [xlen-1:0] code_model [mem_depth];
  logic [xlen-1:0] data_model [mem_depth];
  logic [plen-1:0] code_addrs [$];
  logic [plen-1:0] data_addrs [$];

  pu_riscv_synthesis dut (
    .HCLK     (HCLK),
    .rst_n    (rst_n),
    .dbg_strb (dbg_strb),
    .dbg_we   (dbg_we),
    .dbg_addr (dbg_addr),
    .dbg_dati (dbg_dati),
    .dbg_dato (dbg_dato),
    .dbg_ack  (dbg_ack),
    .dbg_err  (dbg_err)
  );

  initial begin
    HCLK = 1'b0;
    forever #(clk_period / 2) HCLK = ~HCLK;
  end

  // Watchdog
  initial begin
    #((n_access * 5 + 50) * clk_period);
    $display("Watchdog expired before the tests completed");
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_ack_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      flag_errs++;
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] latency: got 0x%0h, expected 0x%0h", got, exp);
      lat_errs++;
    end
  endtask

  task automatic check_ack_count(input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] dbg_ack count: got 0x%0h, expected 0x%0h", got, exp);
      flag_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Access helpers
  ////////////////////////////////////////////////////////////

  // SRAM word index of a byte address
  function automatic logic [mem_aw-1:0] word_idx(input logic [plen-1:0] a);
    return a[9:2];
  endfunction

  // One strobe, then wait for the acknowledge
  task automatic dbg_access(input logic we, input logic [plen-1:0] addr,
                            input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata,
                            output logic err, output int lat);
    bit seen;
    seen = 1'b0;
    lat  = 0;
    @(negedge HCLK);
    dbg_strb = 1'b1;
    dbg_we   = we;
    dbg_addr = addr;
    dbg_dati = wdata;
    // Strobe sampled here
    @(posedge HCLK);
    @(negedge HCLK);
    dbg_strb = 1'b0;
    while (!seen && lat < 10) begin
      @(posedge HCLK);
      lat++;
      @(negedge HCLK);
      seen = dbg_ack;
    end
    rdata = dbg_dato;
    err   = dbg_err;
    if (!seen) begin
      $display("No acknowledge within 10 cycles for the access to address %h", addr);
      misc_errs++;
    end
  endtask

  // Denied accesses answer after 1 cycle, granted ones after 3
  task automatic write_word(input logic [plen-1:0] addr, input logic [xlen-1:0] val,
                            input logic denied);
    logic [xlen-1:0] rd;
    logic            err;
    int              lat;
    dbg_access(1'b1, addr, val, rd, err, lat);
    check_ack_err("dbg_err", err, denied);
    check_latency(lat, denied ? 1 : 3);
  endtask

  task automatic read_word(input logic [plen-1:0] addr, input logic [xlen-1:0] exp,
                           input logic denied);
    logic [xlen-1:0] rd;
    logic            err;
    int              lat;
    dbg_access(1'b0, addr, '0, rd, err, lat);
    check_ack_err("dbg_err", err, denied);
    check_latency(lat, denied ? 1 : 3);
    if (!denied) begin
      check_data("dbg_dato", rd, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    check_ack_err("dbg_ack", dbg_ack, 1'b0);
    check_ack_err("dbg_err", dbg_err, 1'b0);
    check_data("dbg_dato", dbg_dato, '0);
  endtask

  // Random words in region 0
  task automatic code_memory_rw();
    logic [mem_aw-1:0] idx;
    logic [xlen-1:0]   val;
    logic [plen-1:0]   addr;
    for (int i = 0; i < 16; i++) begin
      // Word offsets 0x40 to 0xff, the window the data test reuses
      idx  = 8'h40 + mem_aw'($unsigned($random(seed)) % 192);
      val  = $random(seed);
      addr = pma_base + {idx, 2'b00};
      code_addrs.push_back(addr);
      code_model[idx] = val;
      write_word(addr, val, 1'b0);
    end
    foreach (code_addrs[i]) begin
      read_word(code_addrs[i], code_model[word_idx(code_addrs[i])], 1'b0);
    end
  endtask

  // Random words in region 3, code words must survive
  task automatic data_memory_rw();
    logic [mem_aw-1:0] idx;
    logic [xlen-1:0]   val;
    logic [plen-1:0]   addr;
    for (int i = 0; i < 16; i++) begin
      // Same word index as code write i, a shared array would lose the code word
      idx  = word_idx(code_addrs[i]);
      val  = $random(seed);
      addr = tohost_addr + {idx, 2'b00};
      data_addrs.push_back(addr);
      data_model[idx] = val;
      write_word(addr, val, 1'b0);
    end
    foreach (data_addrs[i]) begin
      read_word(data_addrs[i], data_model[word_idx(data_addrs[i])], 1'b0);
    end
    foreach (code_addrs[i]) begin
      read_word(code_addrs[i], code_model[word_idx(code_addrs[i])], 1'b0);
    end
  endtask

  // Write-only IO words
  task automatic io_regions();
    logic [xlen-1:0] val;
    val = $random(seed);
    write_word(tohost_addr, val, 1'b0);
    data_model[word_idx(tohost_addr)] = val;
    val = $random(seed);
    write_word(uart_tx_addr, val, 1'b0);
    data_model[word_idx(uart_tx_addr)] = val;
    read_word(tohost_addr, '0, 1'b1);
    read_word(uart_tx_addr, '0, 1'b1);
  endtask

  // Mailbox and 0x8000_1400 share data word 0
  task automatic alias_and_priority();
    logic [xlen-1:0] val;
    val = $random(seed);
    write_word(tohost_addr, val, 1'b0);
    data_model[0] = val;
    read_word(32'h8000_1400, val, 1'b0);
    // NA4 region wins over the TOR region above it
    read_word(32'h8000_1080, '0, 1'b1);
  endtask

  task automatic unmapped_denial();
    logic [plen-1:0] holes [4];
    logic [xlen-1:0] val;
    holes = '{32'h8000_0400, 32'h8000_1010, 32'h8000_2000, 32'h7fff_fffc};
    // Known words where the holes would alias
    val = $random(seed);
    write_word(32'h8000_0000, val, 1'b0);
    code_model[8'h00] = val;
    val = $random(seed);
    write_word(32'h8000_03fc, val, 1'b0);
    code_model[8'hff] = val;
    val = $random(seed);
    write_word(32'h8000_1400, val, 1'b0);
    data_model[8'h00] = val;
    val = $random(seed);
    write_word(32'h8000_1410, val, 1'b0);
    data_model[8'h04] = val;
    foreach (holes[i]) begin
      write_word(holes[i], $random(seed), 1'b1);
    end
    read_word(32'h8000_0000, code_model[8'h00], 1'b0);
    read_word(32'h8000_03fc, code_model[8'hff], 1'b0);
    read_word(32'h8000_1400, data_model[8'h00], 1'b0);
    read_word(32'h8000_1410, data_model[8'h04], 1'b0);
  endtask

  // Second strobe while the first transfer runs
  task automatic busy_strobe();
    logic [xlen-1:0] first;
    logic [xlen-1:0] second;
    int              acks;
    acks   = 0;
    first  = $random(seed);
    second = $random(seed);
    write_word(32'h8000_0014, 32'h5a5a_0014, 1'b0);
    code_model[8'h05] = 32'h5a5a_0014;
    @(negedge HCLK);
    dbg_strb = 1'b1;
    dbg_we   = 1'b1;
    dbg_addr = 32'h8000_0010;
    dbg_dati = first;
    @(posedge HCLK);
    @(negedge HCLK);
    // Still high one cycle later with a new address
    dbg_addr = 32'h8000_0014;
    dbg_dati = second;
    repeat (8) begin
      @(posedge HCLK);
      @(negedge HCLK);
      dbg_strb = 1'b0;
      if (dbg_ack) begin
        acks++;
      end
    end
    check_ack_count(acks, 1);
    code_model[8'h04] = first;
    read_word(32'h8000_0010, code_model[8'h04], 1'b0);
    read_word(32'h8000_0014, code_model[8'h05], 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    data_errs = 0;
    flag_errs = 0;
    lat_errs  = 0;
    misc_errs = 0;
    rst_n     = 1'b0;
    dbg_strb  = 1'b0;
    dbg_we    = 1'b0;
    dbg_addr  = '0;
    dbg_dati  = '0;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    rst_n = 1'b1;
    reset_state();
    code_memory_rw();
    data_memory_rw();
    io_regions();
    alias_and_priority();
    unmapped_denial();
    busy_strobe();
    @(negedge HCLK);
    $display("Errors: data %0d, flags %0d, latency %0d, other %0d",
             data_errs, flag_errs, lat_errs, misc_errs);
    if (data_errs + flag_errs + lat_errs + misc_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/pu_ahb3_pkg.sv
logic/pu_pma_checker.sv
logic/pu_dbg_bus_master.sv
logic/pu_ahb3_spram.sv
logic/pu_riscv_synthesis.sv
bench/pu_riscv_synthesis_tb.sv

// File: Bender.yml
package:
  name: pu_riscv_synthesis

sources:
  # RTL in compile order
  - files:
      - logic/pu_ahb3_pkg.sv
      - logic/pu_pma_checker.sv
      - logic/pu_dbg_bus_master.sv
      - logic/pu_ahb3_spram.sv
      - logic/pu_riscv_synthesis.sv

  # Testbench
  - target: test
    files:
      - bench/pu_riscv_synthesis_tb.sv
